/* src/divsqrt_pkg.sv */
/* Shared widths, types and request/response structs of the divide and square-root unit.
   Modules take it with a wildcard import in their header. */
package divsqrt_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Operand and result width, must stay even for the square root
  localparam int unsigned DATA_WIDTH = 16;

  // Caller tag width
  localparam int unsigned TAG_WIDTH = 4;

  // One operand or one result
  typedef logic [DATA_WIDTH-1:0] operand_t;

  // Tag travelling alongside an operation
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // ----------------------------------------------------------------------
  // Operation encoding
  // ----------------------------------------------------------------------

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // ----------------------------------------------------------------------
  // Handshake payloads
  // ----------------------------------------------------------------------

  // Request as seen at the input, operand_b unused for a square root
  typedef struct packed {
    operand_t operand_a;
    operand_t operand_b;
    op_e      op;
    tag_t     tag;
  } in_req_t;

  // Response as seen at the output
  typedef struct packed {
    operand_t result;
    logic     div_zero;  // Divisor was zero, result forced to all ones
    tag_t     tag;
  } out_rsp_t;

endpackage

/* src/divsqrt_in_pipe.sv */
/* Input register chain of the divide/sqrt unit with valid/ready per stage.
   NumInRegs stages, zero gives a plain pass-through. */
`timescale 1ns/1ps

module divsqrt_in_pipe import divsqrt_pkg::*; #(
  parameter int unsigned NumInRegs = 1
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    flush_i,
  // Upstream side
  input  in_req_t req_i,
  input  logic    valid_i,
  output logic    ready_o,
  // Towards control
  output in_req_t req_o,
  output logic    valid_o,
  input  logic    ready_i,
  // Any stage occupied
  output logic    busy_o
);

  // Index i holds the signal after i register stages
  in_req_t [0:NumInRegs] stage_req;
  logic    [0:NumInRegs] stage_valid;
  // Ready travels backwards combinationally
  logic    [0:NumInRegs] stage_ready;

  // Chain entry from the upstream port
  assign stage_req[0]   = req_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  // ----------------------------------------------------------------------
  // Register stages
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NumInRegs; i++) begin : gen_stage
    logic load;

    // Advance when the next stage takes our item or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    // Only move payload when something real is present
    assign load = stage_ready[i] & stage_valid[i];

    // Valid bit, flush drops whatever is in the stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload enable register
    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        stage_req[i+1] <= stage_req[i];
      end
    end
  end

  // Chain exit towards control
  assign stage_ready[NumInRegs] = ready_i;
  assign req_o                  = stage_req[NumInRegs];
  assign valid_o                = stage_valid[NumInRegs];

  // Occupancy of the registered stages only
  if (NumInRegs > 0) begin : gen_busy
    assign busy_o = |stage_valid[1:NumInRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

endmodule

/* src/divsqrt_ctrl.sv */
/* Control FSM between the input pipe and the iterative engine.
   Starts operations, keeps the tag and holds a result under back-pressure. */
`timescale 1ns/1ps

module divsqrt_ctrl import divsqrt_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  // Request from the input pipe
  input  in_req_t  req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  // Engine control
  output logic     start_div_o,
  output logic     start_sqrt_o,
  output logic     kill_o,
  output operand_t operand_a_o,
  output operand_t operand_b_o,
  // Engine status
  input  logic     engine_ready_i,
  input  logic     engine_done_i,
  input  operand_t engine_result_i,
  input  logic     engine_div_zero_i,
  // Response to the output pipe
  output out_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output logic     busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e   state_q, state_d;
  logic     in_ready;
  logic     op_starting;
  logic     hold_en;
  tag_t     tag_q;
  operand_t held_result_q;
  logic     held_div_zero_q;

  // Starts gated by FSM ready and dropped on flush
  assign op_starting  = req_valid_i & in_ready & ~flush_i;
  assign start_div_o  = op_starting & (req_i.op == OP_DIV);
  assign start_sqrt_o = op_starting & (req_i.op == OP_SQRT);
  assign operand_a_o  = req_i.operand_a;
  assign operand_b_o  = req_i.operand_b;
  assign kill_o       = flush_i;
  assign req_ready_o  = in_ready;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_comb begin : fsm
    in_ready    = 1'b0;
    rsp_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;
    unique case (state_q)
      // Waiting for work
      IDLE: begin
        in_ready = engine_ready_i;
        if (req_valid_i && in_ready) begin
          state_d = BUSY;
        end
      end
      // Engine iterating
      BUSY: begin
        busy_o = 1'b1;
        if (engine_done_i) begin
          rsp_valid_o = 1'b1;
          if (rsp_ready_i) begin
            // Back-to-back issue if another request waits
            in_ready = engine_ready_i;
            state_d  = (req_valid_i && in_ready) ? BUSY : IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Result parked until downstream takes it
      HOLD: begin
        busy_o      = 1'b1;
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          in_ready = engine_ready_i;
          state_d  = (req_valid_i && in_ready) ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush wins over everything
    if (flush_i) begin
      busy_o      = 1'b0;
      rsp_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : state_reg
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag capture at start, hold register when done meets a stall
  assign hold_en = engine_done_i & ~rsp_ready_i;

  always_ff @(posedge clk_i) begin : payload_regs
    if (op_starting) begin
      tag_q <= req_i.tag;
    end
    if (hold_en) begin
      held_result_q   <= engine_result_i;
      held_div_zero_q <= engine_div_zero_i;
    end
  end

  // Output select, held data first
  assign rsp_o.result   = (state_q == HOLD) ? held_result_q : engine_result_i;
  assign rsp_o.div_zero = (state_q == HOLD) ? held_div_zero_q : engine_div_zero_i;
  assign rsp_o.tag      = tag_q;

endmodule

/* src/divsqrt_iter_engine.sv */
/* Iterative restoring divider and square-root engine, one result bit per cycle.
   Pulse a start, wait for done, kill aborts at once. */
`timescale 1ns/1ps

module divsqrt_iter_engine import divsqrt_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     start_div_i,
  input  logic     start_sqrt_i,
  input  logic     kill_i,
  input  operand_t operand_a_i,
  input  operand_t operand_b_i,
  output logic     ready_o,
  output logic     done_o,
  output operand_t result_o,
  output logic     div_zero_o
);

  localparam int unsigned HalfW = DATA_WIDTH / 2;
  // Two spare bits for the square-root trial value
  localparam int unsigned RemW  = DATA_WIDTH + 2;
  localparam int unsigned CntW  = $clog2(DATA_WIDTH);

  typedef logic [RemW-1:0]  rem_t;
  typedef logic [HalfW-1:0] root_t;
  typedef logic [CntW-1:0]  cnt_t;

  // Control state
  logic     busy_q;
  cnt_t     cnt_q;
  // Datapath state
  logic     is_sqrt_q;
  logic     div_zero_q;
  rem_t     rem_q;
  operand_t acc_q;      // Dividend shifting into quotient, or radicand
  root_t    root_q;
  operand_t divisor_q;

  logic     start;
  logic     step_en;
  // Step inputs, taken from the ports in the start cycle
  logic     cur_sqrt;
  rem_t     cur_rem;
  operand_t cur_acc;
  root_t    cur_root;
  operand_t cur_divisor;
  // Step results
  rem_t     div_trial;
  rem_t     sqrt_trial;
  rem_t     sqrt_sub;
  logic     div_ge;
  logic     sqrt_ge;
  rem_t     rem_d;
  operand_t acc_d;
  root_t    root_d;

  assign start   = start_div_i | start_sqrt_i;
  assign done_o  = busy_q & (cnt_q == '0);
  assign ready_o = ~busy_q | done_o;
  // First step happens on the start edge itself
  assign step_en = start | (busy_q & ~done_o);

  always_comb begin : step_src
    if (start) begin
      cur_sqrt    = start_sqrt_i;
      cur_rem     = '0;
      cur_acc     = operand_a_i;
      cur_root    = '0;
      cur_divisor = operand_b_i;
    end else begin
      cur_sqrt    = is_sqrt_q;
      cur_rem     = rem_q;
      cur_acc     = acc_q;
      cur_root    = root_q;
      cur_divisor = divisor_q;
    end
  end

  // ----------------------------------------------------------------------
  // One restoring step
  // ----------------------------------------------------------------------
  always_comb begin : restoring_step
    // Divide brings down one dividend bit
    div_trial  = {cur_rem[RemW-2:0], cur_acc[DATA_WIDTH-1]};
    div_ge     = (div_trial >= rem_t'(cur_divisor));
    // Square root brings down two radicand bits against 4*root+1
    sqrt_trial = {cur_rem[RemW-3:0], cur_acc[DATA_WIDTH-1 -: 2]};
    sqrt_sub   = rem_t'({cur_root, 2'b01});
    sqrt_ge    = (sqrt_trial >= sqrt_sub);
    if (cur_sqrt) begin
      rem_d  = sqrt_ge ? (sqrt_trial - sqrt_sub) : sqrt_trial;
      acc_d  = {cur_acc[DATA_WIDTH-3:0], 2'b00};
      root_d = {cur_root[HalfW-2:0], sqrt_ge};
    end else begin
      rem_d  = div_ge ? (div_trial - rem_t'(cur_divisor)) : div_trial;
      acc_d  = {cur_acc[DATA_WIDTH-2:0], div_ge};
      root_d = cur_root;
    end
  end

  // Iteration counter, loaded with steps still left after the first
  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_regs
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= start_sqrt_i ? cnt_t'(HalfW - 1) : cnt_t'(DATA_WIDTH - 1);
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : datapath_regs
    if (step_en) begin
      rem_q  <= rem_d;
      acc_q  <= acc_d;
      root_q <= root_d;
    end
    if (start) begin
      is_sqrt_q  <= start_sqrt_i;
      div_zero_q <= start_div_i & (operand_b_i == '0);
      divisor_q  <= operand_b_i;
    end
  end

  // Zero divisor forces all ones
  assign result_o   = is_sqrt_q ? operand_t'(root_q) : (div_zero_q ? '1 : acc_q);
  assign div_zero_o = div_zero_q & ~is_sqrt_q;

endmodule

/* src/divsqrt_out_pipe.sv */
/* Output register chain of the divide/sqrt unit with valid/ready per stage.
   The last stage drives the unit outputs. */
`timescale 1ns/1ps

module divsqrt_out_pipe import divsqrt_pkg::*; #(
  parameter int unsigned NumOutRegs = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  // From control
  input  out_rsp_t rsp_i,
  input  logic     valid_i,
  output logic     ready_o,
  // Downstream side
  output out_rsp_t rsp_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     busy_o
);

  out_rsp_t [0:NumOutRegs] stage_rsp;
  logic     [0:NumOutRegs] stage_valid;
  logic     [0:NumOutRegs] stage_ready;

  assign stage_rsp[0]   = rsp_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  // ----------------------------------------------------------------------
  // Register stages
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NumOutRegs; i++) begin : gen_stage
    logic load;

    // Pop when downstream is ready or holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        stage_rsp[i+1] <= stage_rsp[i];
      end
    end
  end

  // Downstream ready enters at the tail
  assign stage_ready[NumOutRegs] = ready_i;
  assign rsp_o                   = stage_rsp[NumOutRegs];
  assign valid_o                 = stage_valid[NumOutRegs];

  if (NumOutRegs > 0) begin : gen_busy
    assign busy_o = |stage_valid[1:NumOutRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

endmodule

/* src/divsqrt_multi.sv */
/* Top level of the multi-cycle integer divide and square-root unit.
   Requests in with valid/ready, responses out in request order. */
`timescale 1ns/1ps

module divsqrt_multi import divsqrt_pkg::*; #(
  parameter int unsigned NumInRegs  = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  // Input handshake
  input  in_req_t  req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  // Output handshake
  output out_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  // Items in flight
  output logic     busy_o
);

  // Input pipe to control
  in_req_t  pipe_req;
  logic     pipe_valid;
  logic     pipe_ready;
  // Control to engine
  logic     start_div;
  logic     start_sqrt;
  logic     kill;
  operand_t operand_a;
  operand_t operand_b;
  // Engine to control
  logic     engine_ready;
  logic     engine_done;
  operand_t engine_result;
  logic     engine_div_zero;
  // Control to output pipe
  out_rsp_t ctrl_rsp;
  logic     ctrl_valid;
  logic     ctrl_ready;
  // Busy contributions
  logic     busy_in;
  logic     busy_ctrl;
  logic     busy_out;

  // ----------------------------------------------------------------------
  // Input side
  // ----------------------------------------------------------------------
  divsqrt_in_pipe #(
    .NumInRegs ( NumInRegs )
  ) i_in_pipe (
    .clk_i, .arst_n_i, .flush_i,
    .req_i, .valid_i ( in_valid_i ), .ready_o ( in_ready_o ),
    .req_o ( pipe_req ), .valid_o ( pipe_valid ), .ready_i ( pipe_ready ),
    .busy_o ( busy_in )
  );

  // ----------------------------------------------------------------------
  // Processing
  // ----------------------------------------------------------------------
  divsqrt_ctrl i_ctrl (
    .clk_i, .arst_n_i, .flush_i,
    .req_i ( pipe_req ), .req_valid_i ( pipe_valid ), .req_ready_o ( pipe_ready ),
    .start_div_o ( start_div ), .start_sqrt_o ( start_sqrt ), .kill_o ( kill ),
    .operand_a_o ( operand_a ), .operand_b_o ( operand_b ),
    .engine_ready_i ( engine_ready ), .engine_done_i ( engine_done ),
    .engine_result_i ( engine_result ), .engine_div_zero_i ( engine_div_zero ),
    .rsp_o ( ctrl_rsp ), .rsp_valid_o ( ctrl_valid ), .rsp_ready_i ( ctrl_ready ),
    .busy_o ( busy_ctrl )
  );

  divsqrt_iter_engine i_engine (
    .clk_i, .arst_n_i,
    .start_div_i ( start_div ), .start_sqrt_i ( start_sqrt ), .kill_i ( kill ),
    .operand_a_i ( operand_a ), .operand_b_i ( operand_b ),
    .ready_o ( engine_ready ), .done_o ( engine_done ),
    .result_o ( engine_result ), .div_zero_o ( engine_div_zero )
  );

  // ----------------------------------------------------------------------
  // Output side
  // ----------------------------------------------------------------------
  divsqrt_out_pipe #(
    .NumOutRegs ( NumOutRegs )
  ) i_out_pipe (
    .clk_i, .arst_n_i, .flush_i,
    .rsp_i ( ctrl_rsp ), .valid_i ( ctrl_valid ), .ready_o ( ctrl_ready ),
    .rsp_o, .valid_o ( out_valid_o ), .ready_i ( out_ready_i ),
    .busy_o ( busy_out )
  );

  // Anything held anywhere counts as busy
  assign busy_o = busy_in | busy_ctrl | busy_out;

endmodule

/* bench/divsqrt_multi_assert.sv */
/* Concurrent checks on the output handshake, flush and reset of the unit.
   Bound into every divsqrt_multi instance. */
`timescale 1ns/1ps

module divsqrt_multi_assert import divsqrt_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input logic     flush_i,
  input out_rsp_t rsp_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input logic     busy_o
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Offered response held until taken
  rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
    (out_valid_o && !out_ready_i) |=> $stable(rsp_o))
    else begin
      $error("rsp_o changed while stalled");
      fail_count++;
    end

  // Flush empties the whole unit in one cycle
  flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> (!out_valid_o && !busy_o))
    else begin
      $error("out_valid_o or busy_o high after flush");
      fail_count++;
    end

  // No output during reset
  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
    else begin
      $error("out_valid_o high during reset");
      fail_count++;
    end

endmodule

bind divsqrt_multi divsqrt_multi_assert i_assert (
  .clk_i       ( clk_i ),
  .arst_n_i    ( arst_n_i ),
  .flush_i     ( flush_i ),
  .rsp_o       ( rsp_o ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_o      ( busy_o )
);

/* bench/tb_divsqrt_multi.sv */
/* Testbench for the divide and square-root unit with random stimulus and a scoreboard.
   Expected responses are queued at input acceptance and compared at output transfer. */
`timescale 1ns/1ps

module tb_divsqrt_multi;
  import divsqrt_pkg::*;

  localparam int unsigned Timeout = 2000;

  logic     clk_i;
  logic     arst_n_i;
  logic     flush_i;
  in_req_t  req_i;
  logic     in_valid_i;
  logic     in_ready_o;
  out_rsp_t rsp_o;
  logic     out_valid_o;
  logic     out_ready_i;
  logic     busy_o;

  // Scoreboard and bookkeeping
  out_rsp_t    exp_q[$];
  int unsigned value_errs;
  int unsigned other_errs;
  string       cur_test;
  logic [31:0] lcg_state;
  logic [31:0] stall_state;
  logic        stall_en;
  logic        ready_level;

  divsqrt_multi #(
    .NumInRegs  ( 1 ),
    .NumOutRegs ( 1 )
  ) dut0 (
    .clk_i, .arst_n_i, .flush_i,
    .req_i, .in_valid_i, .in_ready_o,
    .rsp_o, .out_valid_o, .out_ready_i,
    .busy_o
  );

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Random numbers and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper bits have the longest period
  function automatic operand_t rand_operand();
    lcg_state = lcg_step(lcg_state);
    return lcg_state[31 -: DATA_WIDTH];
  endfunction

  function automatic in_req_t make_req(input op_e op, input operand_t a, input operand_t b,
                                       input tag_t tag);
    in_req_t r;
    r.operand_a = a;
    r.operand_b = b;
    r.op        = op;
    r.tag       = tag;
    return r;
  endfunction

  // Floor quotient, all ones on zero divisor, floor root by search
  function automatic out_rsp_t ref_result(input in_req_t r);
    out_rsp_t    rsp;
    int unsigned root;
    rsp.tag      = r.tag;
    rsp.div_zero = 1'b0;
    if (r.op == OP_SQRT) begin
      root = 0;
      while ((root + 1) * (root + 1) <= r.operand_a) begin
        root++;
      end
      rsp.result = operand_t'(root);
    end else if (r.operand_b == '0) begin
      rsp.result   = '1;
      rsp.div_zero = 1'b1;
    end else begin
      rsp.result = r.operand_a / r.operand_b;
    end
    return rsp;
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_rsp(input string name, input out_rsp_t exp, input out_rsp_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h div_zero=%b tag=%h actual %h div_zero=%b tag=%h",
               name, exp.result, exp.div_zero, exp.tag, act.result, act.div_zero, act.tag);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      value_errs++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Drivers, called on a rising edge
  // ----------------------------------------------------------------------
  task automatic send_req(input in_req_t r);
    int unsigned waited;
    req_i      <= r;
    in_valid_i <= 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!in_ready_o && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      $display("Timeout in %s: request was never accepted", cur_test);
      other_errs++;
    end
    in_valid_i <= 1'b0;
  endtask

  // Divisor shifted down for a spread of quotient sizes, never zero
  task automatic send_random(input op_e op);
    operand_t a;
    operand_t b;
    operand_t extra;
    a     = rand_operand();
    b     = rand_operand();
    extra = rand_operand();
    b     = b >> extra[3:0];
    if (b == '0) begin
      b = operand_t'(1);
    end
    send_req(make_req(op, a, b, tag_t'(extra[7:4])));
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while ((exp_q.size() != 0 || busy_o) && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout in %s: %0d responses never arrived", cur_test, exp_q.size());
      other_errs++;
      exp_q.delete();
    end else if (busy_o) begin
      $display("Timeout in %s: busy_o stayed high with nothing outstanding", cur_test);
      other_errs++;
    end
  endtask

  // Output ready, random about three cycles in four when stalling
  always @(posedge clk_i) begin : ready_drive
    if (stall_en) begin
      stall_state = lcg_step(stall_state);
      out_ready_i <= stall_state[31] | stall_state[30];
    end else begin
      out_ready_i <= ready_level;
    end
  end

  // Scoreboard, flush drops everything in flight
  always @(posedge clk_i) begin : scoreboard
    if (arst_n_i) begin
      if (flush_i) begin
        exp_q.delete();
      end else begin
        if (in_valid_i && in_ready_o) begin
          exp_q.push_back(ref_result(req_i));
        end
        if (out_valid_o && out_ready_i) begin
          if (exp_q.size() == 0) begin
            $display("Unexpected response with tag %h in %s", rsp_o.tag, cur_test);
            other_errs++;
          end else begin
            check_rsp(cur_test, exp_q.pop_front(), rsp_o);
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    int unsigned waited;
    operand_t    pick;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    stall_en    = 1'b0;
    ready_level = 1'b1;
    lcg_state   = 32'd13;
    stall_state = 32'd13;
    value_errs  = 0;
    other_errs  = 0;
    cur_test    = "reset";
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_bit("reset out_valid", 1'b0, out_valid_o);
    check_bit("reset busy", 1'b0, busy_o);
    waited = 0;
    while (!in_ready_o && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      $display("Timeout after reset: in_ready_o never went high");
      other_errs++;
    end

    cur_test = "divide";
    for (int i = 0; i < 200; i++) begin
      send_random(OP_DIV);
    end
    wait_drain();

    cur_test = "divide by zero";
    for (int i = 0; i < 8; i++) begin
      send_req(make_req(OP_DIV, rand_operand(), '0, tag_t'(i)));
    end
    wait_drain();

    // Edge radicands first, then random roots mixed with divides
    cur_test = "square root";
    send_req(make_req(OP_SQRT, '0, '0, 4'h1));
    send_req(make_req(OP_SQRT, operand_t'(1), '0, 4'h2));
    send_req(make_req(OP_SQRT, operand_t'(65025), '0, 4'h3));
    send_req(make_req(OP_SQRT, '1, '0, 4'h4));
    for (int i = 0; i < 200; i++) begin
      send_random(OP_SQRT);
      pick = rand_operand();
      if (pick[0]) begin
        send_random(OP_DIV);
      end
    end
    wait_drain();

    cur_test = "back-pressure";
    stall_en <= 1'b1;
    for (int i = 0; i < 150; i++) begin
      pick = rand_operand();
      send_random(pick[1] ? OP_SQRT : OP_DIV);
    end
    wait_drain();
    stall_en <= 1'b0;

    // Two operations stuck behind a blocked output, then a flush
    cur_test    = "flush";
    ready_level <= 1'b0;
    @(posedge clk_i);
    send_random(OP_DIV);
    send_random(OP_SQRT);
    // First result parked in the output stage, second held in control
    // Input stage empty again, so the request offered with the flush is taken
    repeat (30) @(posedge clk_i);
    flush_i    <= 1'b1;
    req_i      <= make_req(OP_DIV, operand_t'(100), operand_t'(7), 4'h9);
    in_valid_i <= 1'b1;
    @(posedge clk_i);
    flush_i    <= 1'b0;
    in_valid_i <= 1'b0;
    @(posedge clk_i);
    check_bit("flush out_valid", 1'b0, out_valid_o);
    check_bit("flush busy", 1'b0, busy_o);
    ready_level <= 1'b1;
    // Any output here is caught by the scoreboard as unexpected
    repeat (40) @(posedge clk_i);
    cur_test = "after flush";
    for (int i = 0; i < 10; i++) begin
      send_random(i[0] ? OP_SQRT : OP_DIV);
    end
    wait_drain();

    $display("Run complete: %0d value errors, %0d other errors, %0d assertion errors",
             value_errs, other_errs, dut0.i_assert.fail_count);
    if (value_errs == 0 && other_errs == 0 && dut0.i_assert.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
src/divsqrt_pkg.sv
src/divsqrt_in_pipe.sv
src/divsqrt_ctrl.sv
src/divsqrt_iter_engine.sv
src/divsqrt_out_pipe.sv
src/divsqrt_multi.sv
bench/divsqrt_multi_assert.sv
bench/tb_divsqrt_multi.sv

/* Bender.yml */
package:
  name: divsqrt_multi

sources:
  - files:
      - src/divsqrt_pkg.sv
      - src/divsqrt_in_pipe.sv
      - src/divsqrt_ctrl.sv
      - src/divsqrt_iter_engine.sv
      - src/divsqrt_out_pipe.sv
      - src/divsqrt_multi.sv
  - target: test
    files:
      - bench/divsqrt_multi_assert.sv
      - bench/tb_divsqrt_multi.sv
